//--- source/eth_pkg.sv
// Shared addresses, register map, frame constants and enums for the Ethernet TX and ARP block
package eth_pkg;

    localparam logic [47:0] LOCAL_MAC    = 48'h02_00_00_00_00_01; // Locally administered
    localparam logic [31:0] LOCAL_IP     = 32'hC0_A8_01_64;       // 192.168.1.100
    localparam logic [15:0] UDP_SRC_PORT = 16'd5000;
    localparam logic [15:0] UDP_DST_PORT = 16'd6000;
    localparam logic [15:0] ETH_TYPE_IP  = 16'h0800;
    localparam logic [15:0] ETH_TYPE_ARP = 16'h0806;

    localparam int MIN_FRAME_LEN = 60; // FCS added downstream
    localparam int MAX_PAYLOAD   = 64;

    // Host register word addresses
    localparam logic [5:0] REG_CTRL         = 6'h00; // Wr bit0 start, rd bit0 busy
    localparam logic [5:0] REG_DMAC_LO      = 6'h01;
    localparam logic [5:0] REG_DMAC_HI      = 6'h02;
    localparam logic [5:0] REG_DIP          = 6'h03;
    localparam logic [5:0] REG_LEN          = 6'h04;
    localparam logic [5:0] REG_PAYLOAD_BASE = 6'h10; // 16 words, big-endian bytes

    typedef enum logic [15:0] {
        ARP_REQUEST = 16'd1,
        ARP_REPLY   = 16'd2
    } arp_op_e;

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        BODY,
        PAD
    } tx_state_e;

endpackage

//--- source/eth_host_regs.sv
// Wishbone classic host registers with payload memory, start pulse and learned MAC
`timescale 1ns/1ps

module eth_host_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [5:0]           wb_adr,
    input  logic [31:0]          wb_dat_w,
    output logic [31:0]          wb_dat_r,
    output logic                 wb_ack,
    input  logic                 tx_busy,
    input  logic                 arp_rx_done,
    input  eth_pkg::arp_op_e     arp_rx_type,
    input  logic [47:0]          arp_rx_mac,
    input  logic [5:0]           pay_addr,
    output logic                 tx_start_en,
    output logic [47:0]          tx_des_mac,
    output logic [31:0]          tx_des_ip,
    output logic [6:0]           tx_len,
    output logic [7:0]           pay_data
);

    logic [31:0] pay_mem [eth_pkg::MAX_PAYLOAD/4]; // Payload words
    logic        wb_hit;                           // Strobe seen, not yet acked
    logic        pay_sel;                          // Address in payload window

    assign wb_hit  = wb_cyc && wb_stb && !wb_ack;
    assign pay_sel = wb_adr[5:4] == eth_pkg::REG_PAYLOAD_BASE[5:4];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack      <= 1'b0;
            tx_start_en <= 1'b0;
            tx_des_mac  <= '0;
            tx_des_ip   <= '0;
            tx_len      <= '0;
        end else begin
            wb_ack      <= wb_hit; // One cycle, never back to back
            tx_start_en <= wb_hit && wb_we && wb_adr == eth_pkg::REG_CTRL
                           && wb_dat_w[0] && !tx_busy;
            if (wb_hit && wb_we && !tx_busy) begin // Frozen during a send
                case (wb_adr)
                    eth_pkg::REG_DMAC_LO: tx_des_mac[31:0]  <= wb_dat_w;
                    eth_pkg::REG_DMAC_HI: tx_des_mac[47:32] <= wb_dat_w[15:0];
                    eth_pkg::REG_DIP:     tx_des_ip         <= wb_dat_w;
                    eth_pkg::REG_LEN:     tx_len            <= wb_dat_w[6:0];
                    default: ;
                endcase
            end
            if (arp_rx_done && arp_rx_type == eth_pkg::ARP_REPLY)
                tx_des_mac <= arp_rx_mac; // Learned from peer reply
        end
    end

    always_ff @(posedge clk) begin
        if (wb_hit && wb_we && pay_sel) pay_mem[wb_adr[3:0]] <= wb_dat_w;
        pay_data <= pay_mem[pay_addr[5:2]][{~pay_addr[1:0], 3'b000} +: 8]; // Byte 0 is MSB
        if (wb_hit) begin
            if (pay_sel) begin
                wb_dat_r <= pay_mem[wb_adr[3:0]];
            end else begin
                case (wb_adr)
                    eth_pkg::REG_CTRL:    wb_dat_r <= {31'd0, tx_busy};
                    eth_pkg::REG_DMAC_LO: wb_dat_r <= tx_des_mac[31:0];
                    eth_pkg::REG_DMAC_HI: wb_dat_r <= {16'd0, tx_des_mac[47:32]};
                    eth_pkg::REG_DIP:     wb_dat_r <= tx_des_ip;
                    eth_pkg::REG_LEN:     wb_dat_r <= {25'd0, tx_len};
                    default:              wb_dat_r <= 32'd0;
                endcase
            end
        end
    end

    // Lengths outside 1 to 64 overrun the payload memory in the UDP builder
    len_range: assert property (@(posedge clk) disable iff (!rst_n)
        wb_hit && wb_we && wb_adr == eth_pkg::REG_LEN
        |-> wb_dat_w >= 32'd1 && wb_dat_w <= 32'(eth_pkg::MAX_PAYLOAD))
        else $error("eth_host_regs: payload length outside 1 to 64");

endmodule

//--- source/arp_rx.sv
// ARP receive parser for GMII bytes, reports requests and replies aimed at the local IP
`timescale 1ns/1ps

module arp_rx (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             gmii_rxdv,
    input  logic [7:0]       gmii_rxd,
    output logic             arp_rx_done,
    output eth_pkg::arp_op_e arp_rx_type,
    output logic [47:0]      arp_rx_mac,
    output logic [31:0]      arp_rx_ip
);

    logic [5:0]  cnt;      // Byte index within frame
    logic [15:0] eth_type;
    logic [15:0] op;
    logic [31:0] tip;      // Target protocol address
    logic        match;    // Final byte completes a valid ARP for us

    assign match = eth_type == eth_pkg::ETH_TYPE_ARP
                   && (op == eth_pkg::ARP_REQUEST || op == eth_pkg::ARP_REPLY)
                   && {tip[23:0], gmii_rxd} == eth_pkg::LOCAL_IP;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt         <= '0;
            arp_rx_done <= 1'b0;
        end else begin
            arp_rx_done <= 1'b0;
            if (!gmii_rxdv) begin
                cnt <= '0; // Early drop discards the frame
            end else begin
                if (cnt != 6'd63) cnt <= cnt + 6'd1; // Saturate on long frames
                if (cnt == 6'd41) arp_rx_done <= match;
            end
        end
    end

    // Field capture by byte offset
    always_ff @(posedge clk) begin
        if (gmii_rxdv) begin
            if (cnt inside {[6'd12:6'd13]}) eth_type <= {eth_type[7:0], gmii_rxd};
            if (cnt inside {[6'd20:6'd21]}) op <= {op[7:0], gmii_rxd};
            if (cnt inside {[6'd22:6'd27]}) arp_rx_mac <= {arp_rx_mac[39:0], gmii_rxd};
            if (cnt inside {[6'd28:6'd31]}) arp_rx_ip <= {arp_rx_ip[23:0], gmii_rxd};
            if (cnt inside {[6'd38:6'd41]}) tip <= {tip[23:0], gmii_rxd};
            if (cnt == 6'd41) arp_rx_type <= eth_pkg::arp_op_e'(op);
        end
    end

endmodule

//--- source/arp_tx.sv
// ARP frame builder, sends a padded 60-byte request or reply on a GMII byte stream
`timescale 1ns/1ps

module arp_tx (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             arp_tx_en,
    input  eth_pkg::arp_op_e arp_tx_type,
    input  logic [47:0]      tgt_mac,
    input  logic [31:0]      tgt_ip,
    output logic             arp_tx_done,
    output logic             arp_gmii_txen,
    output logic [7:0]       arp_gmii_txd
);

    eth_pkg::tx_state_e state;
    logic [5:0]         cnt;      // Byte index
    logic [335:0]       frame_q;  // 42 header and body bytes, MSB first
    logic [47:0]        eth_dst;
    logic [47:0]        tha;      // Target hardware address field
    logic               is_req;

    assign is_req        = arp_tx_type == eth_pkg::ARP_REQUEST;
    assign eth_dst       = is_req ? 48'hFFFF_FFFF_FFFF : tgt_mac; // Broadcast for request
    assign tha           = is_req ? 48'd0 : tgt_mac;
    assign arp_gmii_txen = state != eth_pkg::IDLE;
    assign arp_gmii_txd  = frame_q[335:328];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= eth_pkg::IDLE;
            cnt         <= '0;
            arp_tx_done <= 1'b0;
        end else begin
            arp_tx_done <= 1'b0;
            if (state != eth_pkg::IDLE) cnt <= cnt + 6'd1;
            case (state)
                eth_pkg::IDLE: begin
                    if (arp_tx_en) begin
                        state <= eth_pkg::HEADER;
                        cnt   <= '0;
                    end
                end
                eth_pkg::HEADER: if (cnt == 6'd13) state <= eth_pkg::BODY;
                eth_pkg::BODY:   if (cnt == 6'd41) state <= eth_pkg::PAD;
                default: begin
                    if (cnt == 6'(eth_pkg::MIN_FRAME_LEN - 1)) begin
                        state       <= eth_pkg::IDLE;
                        arp_tx_done <= 1'b1; // Cycle after last byte
                    end
                end
            endcase
        end
    end

    // Zeros shift in behind the body and form the padding
    always_ff @(posedge clk) begin
        if (state == eth_pkg::IDLE && arp_tx_en) begin
            frame_q <= {eth_dst, eth_pkg::LOCAL_MAC, eth_pkg::ETH_TYPE_ARP,
                        16'h0001, eth_pkg::ETH_TYPE_IP, 8'd6, 8'd4, arp_tx_type,
                        eth_pkg::LOCAL_MAC, eth_pkg::LOCAL_IP, tha, tgt_ip};
        end else begin
            frame_q <= {frame_q[327:0], 8'h00};
        end
    end

    en_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        arp_tx_en |-> state == eth_pkg::IDLE)
        else $error("arp_tx: enable while a frame is in flight");

endmodule

//--- source/udp_tx.sv
// UDP frame builder, sends Ethernet, IPv4 and UDP headers, payload and padding on GMII
`timescale 1ns/1ps

module udp_tx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        udp_tx_en,
    input  logic [47:0] des_mac,
    input  logic [31:0] des_ip,
    input  logic [6:0]  pay_len,
    output logic [5:0]  pay_addr,
    input  logic [7:0]  pay_data,
    output logic        udp_tx_done,
    output logic        udp_gmii_txen,
    output logic [7:0]  udp_gmii_txd
);

    eth_pkg::tx_state_e state;
    logic [6:0]         cnt;      // Byte index, up to 105
    logic [6:0]         pay_idx;  // Payload byte fetched one ahead
    logic [6:0]         pay_end;  // Index of last payload byte
    logic [6:0]         len_q;
    logic [31:0]        dip_q;
    logic [15:0]        csum;
    logic [335:0]       hdr_q;    // 42 header bytes, checksum slot zero

    // Ones' complement header sum, TTL 64, proto 17, ID and flags zero
    function automatic logic [15:0] ip_csum(input logic [31:0] dip, input logic [6:0] len);
        logic [31:0] sum;
        logic [16:0] fold;
        sum  = 32'h4500 + 32'h4011 + 32'd28 + len + eth_pkg::LOCAL_IP[31:16]
               + eth_pkg::LOCAL_IP[15:0] + dip[31:16] + dip[15:0];
        fold = sum[15:0] + sum[31:16];
        fold = fold[15:0] + fold[16];
        return ~fold[15:0];
    endfunction

    assign pay_idx       = cnt - 7'd41;
    assign pay_addr      = pay_idx[5:0];
    assign pay_end       = 7'd41 + len_q;
    assign udp_gmii_txen = state != eth_pkg::IDLE;

    always_comb begin
        case (state)
            eth_pkg::HEADER: begin
                if (cnt == 7'd24)      udp_gmii_txd = csum[15:8];
                else if (cnt == 7'd25) udp_gmii_txd = csum[7:0];
                else                   udp_gmii_txd = hdr_q[335:328];
            end
            eth_pkg::BODY: udp_gmii_txd = pay_data; // Registered memory read
            default:       udp_gmii_txd = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= eth_pkg::IDLE;
            cnt         <= '0;
            udp_tx_done <= 1'b0;
        end else begin
            udp_tx_done <= 1'b0;
            if (state != eth_pkg::IDLE) cnt <= cnt + 7'd1;
            case (state)
                eth_pkg::IDLE: begin
                    if (udp_tx_en) begin
                        state <= eth_pkg::HEADER;
                        cnt   <= '0;
                    end
                end
                eth_pkg::HEADER: if (cnt == 7'd41) state <= eth_pkg::BODY;
                eth_pkg::BODY: begin
                    if (cnt == pay_end) begin
                        if (cnt >= 7'(eth_pkg::MIN_FRAME_LEN - 1)) begin
                            state       <= eth_pkg::IDLE; // Long enough, no padding
                            udp_tx_done <= 1'b1;
                        end else begin
                            state <= eth_pkg::PAD;
                        end
                    end
                end
                default: begin
                    if (cnt == 7'(eth_pkg::MIN_FRAME_LEN - 1)) begin
                        state       <= eth_pkg::IDLE;
                        udp_tx_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == eth_pkg::IDLE && udp_tx_en) begin
            dip_q <= des_ip;
            len_q <= pay_len;
            hdr_q <= {des_mac, eth_pkg::LOCAL_MAC, eth_pkg::ETH_TYPE_IP,
                      16'h4500, {9'd0, pay_len} + 16'd28, 32'd0, 8'd64, 8'd17, 16'd0,
                      eth_pkg::LOCAL_IP, des_ip,
                      eth_pkg::UDP_SRC_PORT, eth_pkg::UDP_DST_PORT,
                      {9'd0, pay_len} + 16'd8, 16'd0}; // UDP checksum unused
        end else begin
            hdr_q <= {hdr_q[327:0], 8'h00};
        end
        if (state == eth_pkg::HEADER && cnt == 7'd0) csum <= ip_csum(dip_q, len_q);
    end

endmodule

//--- source/eth_ctrl.sv
// Transmit controller, picks ARP or UDP, triggers the builders and muxes GMII output
`timescale 1ns/1ps

module eth_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tx_start_en,
    input  logic [47:0]      tx_des_mac,
    input  logic [31:0]      tx_des_ip,
    input  logic             arp_rx_done,
    input  eth_pkg::arp_op_e arp_rx_type,
    input  logic [47:0]      arp_rx_mac,
    input  logic [31:0]      arp_rx_ip,
    output logic             arp_tx_en,
    output eth_pkg::arp_op_e arp_tx_type,
    output logic [47:0]      tgt_mac,
    output logic [31:0]      tgt_ip,
    input  logic             arp_tx_done,
    output logic             udp_tx_en,
    input  logic             udp_tx_done,
    output logic             tx_busy,
    input  logic             arp_gmii_txen,
    input  logic [7:0]       arp_gmii_txd,
    input  logic             udp_gmii_txen,
    input  logic [7:0]       udp_gmii_txd,
    output logic             gmii_txen,
    output logic [7:0]       gmii_txd,
    output logic             gmii_tlast
);

    logic        udp_sel;     // Output select, UDP after reset
    logic        arp_busy;
    logic        udp_busy;
    logic        pend;        // Reply waiting for the UDP builder
    logic [47:0] pend_mac;
    logic [31:0] pend_ip;
    logic        req_trig;    // Host start, MAC unknown
    logic        udp_trig;    // Host start, MAC known
    logic        reply_req;   // Peer asked for our MAC
    logic        reply_fire;
    logic        sel_en;

    assign req_trig   = tx_start_en && tx_des_mac == 48'd0;
    assign udp_trig   = tx_start_en && tx_des_mac != 48'd0;
    assign reply_req  = arp_rx_done && arp_rx_type == eth_pkg::ARP_REQUEST;
    assign reply_fire = (reply_req || pend) && !arp_busy && !udp_busy && !tx_start_en;
    assign tx_busy    = arp_busy || udp_busy || pend || reply_req; // Also holds off host start
    assign sel_en     = udp_sel ? udp_gmii_txen : arp_gmii_txen;
    assign gmii_tlast = gmii_txen && !sel_en; // Registered enable about to fall

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            udp_sel   <= 1'b1;
            arp_busy  <= 1'b0;
            udp_busy  <= 1'b0;
            pend      <= 1'b0;
            arp_tx_en <= 1'b0;
            udp_tx_en <= 1'b0;
            gmii_txen <= 1'b0;
        end else begin
            arp_tx_en <= req_trig || reply_fire;
            udp_tx_en <= udp_trig;
            gmii_txen <= sel_en;
            if (req_trig || reply_fire) udp_sel <= 1'b0;
            else if (arp_tx_done)       udp_sel <= 1'b1;
            if (req_trig || reply_fire) arp_busy <= 1'b1;
            else if (arp_tx_done)       arp_busy <= 1'b0;
            if (udp_trig)         udp_busy <= 1'b1;
            else if (udp_tx_done) udp_busy <= 1'b0;
            if (reply_fire)                  pend <= 1'b0;
            else if (reply_req && !arp_busy) pend <= 1'b1; // Dropped during an ARP send
        end
    end

    always_ff @(posedge clk) begin
        gmii_txd <= udp_sel ? udp_gmii_txd : arp_gmii_txd;
        if (reply_req && !arp_busy) begin
            pend_mac <= arp_rx_mac;
            pend_ip  <= arp_rx_ip;
        end
        if (req_trig) begin
            arp_tx_type <= eth_pkg::ARP_REQUEST;
            tgt_mac     <= 48'd0;
            tgt_ip      <= tx_des_ip;
        end else if (reply_fire) begin
            arp_tx_type <= eth_pkg::ARP_REPLY;
            tgt_mac     <= reply_req ? arp_rx_mac : pend_mac;
            tgt_ip      <= reply_req ? arp_rx_ip : pend_ip;
        end
    end

endmodule

//--- source/eth_subsys_top.sv
// Ethernet transmit and ARP subsystem top, host registers, parser, builders and controller
`timescale 1ns/1ps

module eth_subsys_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [5:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        gmii_rxdv,
    input  logic [7:0]  gmii_rxd,
    output logic        gmii_txen,
    output logic [7:0]  gmii_txd,
    output logic        gmii_tlast
);

    logic             tx_busy;
    logic             tx_start_en;
    logic [47:0]      tx_des_mac;
    logic [31:0]      tx_des_ip;
    logic [6:0]       tx_len;
    logic [5:0]       pay_addr;
    logic [7:0]       pay_data;
    logic             arp_rx_done;
    eth_pkg::arp_op_e arp_rx_type;
    logic [47:0]      arp_rx_mac;
    logic [31:0]      arp_rx_ip;
    logic             arp_tx_en;
    eth_pkg::arp_op_e arp_tx_type;
    logic [47:0]      tgt_mac;
    logic [31:0]      tgt_ip;
    logic             arp_tx_done;
    logic             arp_gmii_txen;
    logic [7:0]       arp_gmii_txd;
    logic             udp_tx_en;
    logic             udp_tx_done;
    logic             udp_gmii_txen;
    logic [7:0]       udp_gmii_txd;

    eth_host_regs u_regs (
        .clk        (clk),        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),     .wb_stb     (wb_stb),     .wb_we      (wb_we),
        .wb_adr     (wb_adr),     .wb_dat_w   (wb_dat_w),   .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),     .tx_busy    (tx_busy),
        .arp_rx_done(arp_rx_done), .arp_rx_type(arp_rx_type), .arp_rx_mac(arp_rx_mac),
        .pay_addr   (pay_addr),   .tx_start_en(tx_start_en),
        .tx_des_mac (tx_des_mac), .tx_des_ip  (tx_des_ip),  .tx_len     (tx_len),
        .pay_data   (pay_data)
    );

    arp_rx u_arp_rx (
        .clk        (clk),         .rst_n      (rst_n),
        .gmii_rxdv  (gmii_rxdv),   .gmii_rxd   (gmii_rxd),
        .arp_rx_done(arp_rx_done), .arp_rx_type(arp_rx_type),
        .arp_rx_mac (arp_rx_mac),  .arp_rx_ip  (arp_rx_ip)
    );

    eth_ctrl u_ctrl (
        .clk          (clk),           .rst_n        (rst_n),
        .tx_start_en  (tx_start_en),   .tx_des_mac   (tx_des_mac),   .tx_des_ip(tx_des_ip),
        .arp_rx_done  (arp_rx_done),   .arp_rx_type  (arp_rx_type),
        .arp_rx_mac   (arp_rx_mac),    .arp_rx_ip    (arp_rx_ip),
        .arp_tx_en    (arp_tx_en),     .arp_tx_type  (arp_tx_type),
        .tgt_mac      (tgt_mac),       .tgt_ip       (tgt_ip),       .arp_tx_done(arp_tx_done),
        .udp_tx_en    (udp_tx_en),     .udp_tx_done  (udp_tx_done),  .tx_busy(tx_busy),
        .arp_gmii_txen(arp_gmii_txen), .arp_gmii_txd (arp_gmii_txd),
        .udp_gmii_txen(udp_gmii_txen), .udp_gmii_txd (udp_gmii_txd),
        .gmii_txen    (gmii_txen),     .gmii_txd     (gmii_txd),     .gmii_tlast(gmii_tlast)
    );

    arp_tx u_arp_tx (
        .clk          (clk),           .rst_n       (rst_n),
        .arp_tx_en    (arp_tx_en),     .arp_tx_type (arp_tx_type),
        .tgt_mac      (tgt_mac),       .tgt_ip      (tgt_ip),
        .arp_tx_done  (arp_tx_done),
        .arp_gmii_txen(arp_gmii_txen), .arp_gmii_txd(arp_gmii_txd)
    );

    udp_tx u_udp_tx (
        .clk          (clk),           .rst_n       (rst_n),
        .udp_tx_en    (udp_tx_en),     .des_mac     (tx_des_mac),   .des_ip(tx_des_ip),
        .pay_len      (tx_len),        .pay_addr    (pay_addr),     .pay_data(pay_data),
        .udp_tx_done  (udp_tx_done),
        .udp_gmii_txen(udp_gmii_txen), .udp_gmii_txd(udp_gmii_txd)
    );

endmodule

//--- sim/eth_subsys_tb.sv
// Testbench for the Ethernet TX and ARP subsystem, random frames checked against a byte model
`timescale 1ns/1ps

module eth_subsys_tb;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [5:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        gmii_rxdv;
    logic [7:0]  gmii_rxd;
    logic        gmii_txen;
    logic [7:0]  gmii_txd;
    logic        gmii_tlast;

    integer     seed = 35;
    int         errors = 0;
    int         checks = 0;
    logic [7:0] got [$];   // Bytes seen on GMII
    logic [7:0] exp_q [$]; // Model frame
    logic [7:0] pay [64];  // Current payload

    eth_subsys_top u_dut (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .gmii_rxdv(gmii_rxdv), .gmii_rxd(gmii_rxd),
        .gmii_txen(gmii_txen), .gmii_txd(gmii_txd), .gmii_tlast(gmii_tlast)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    // One classic cycle, called and returning 1 ns after an edge
    task automatic wb_access(input logic we, input logic [5:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        n        = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_ack && n < 16);
        if (!wb_ack) begin
            errors++;
            $display("Wishbone access to address %h got no ack", adr);
        end
        rdat   = wb_dat_r; // Valid with ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #1;
        if (wb_ack) begin // Ack must be a single cycle
            errors++;
            $display("Fail wb_ack_width: expected 0, actual 1");
        end
    endtask

    task automatic wb_write(input logic [5:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [5:0] adr, output logic [31:0] dat);
        wb_access(1'b0, adr, 32'd0, dat);
    endtask

    task automatic push_bytes(input logic [47:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) exp_q.push_back(v[8*i +: 8]); // MSB first
    endtask

    task automatic pad_frame();
        while (exp_q.size() < eth_pkg::MIN_FRAME_LEN) exp_q.push_back(8'h00);
    endtask

    // Ethernet, IPv4 and UDP headers, payload, padding
    task automatic build_udp(input logic [47:0] mac, input logic [31:0] ip, input int len);
        logic [31:0] sum;
        exp_q.delete();
        push_bytes(mac, 6);
        push_bytes(eth_pkg::LOCAL_MAC, 6);
        push_bytes(eth_pkg::ETH_TYPE_IP, 2);
        push_bytes(16'h4500, 2);
        push_bytes(len + 28, 2);     // IP total length
        push_bytes(32'd0, 4);        // ID, flags, offset
        push_bytes(16'h4011, 2);     // TTL 64, UDP
        push_bytes(16'd0, 2);        // Checksum slot
        push_bytes(eth_pkg::LOCAL_IP, 4);
        push_bytes(ip, 4);
        push_bytes(eth_pkg::UDP_SRC_PORT, 2);
        push_bytes(eth_pkg::UDP_DST_PORT, 2);
        push_bytes(len + 8, 2);
        push_bytes(16'd0, 2);
        sum = 32'd0;
        for (int i = 14; i < 34; i += 2) sum += {exp_q[i], exp_q[i+1]};
        sum = sum[15:0] + sum[31:16];
        sum = sum[15:0] + sum[31:16]; // Second carry fold
        exp_q[24] = ~sum[15:8];
        exp_q[25] = ~sum[7:0];
        for (int i = 0; i < len; i++) exp_q.push_back(pay[i]);
        pad_frame();
    endtask

    task automatic build_arp(input logic [15:0] op, input logic [47:0] dst,
                             input logic [47:0] tha, input logic [31:0] tip);
        exp_q.delete();
        push_bytes(dst, 6);
        push_bytes(eth_pkg::LOCAL_MAC, 6);
        push_bytes(eth_pkg::ETH_TYPE_ARP, 2);
        push_bytes(16'h0001, 2);               // Ethernet hardware
        push_bytes(eth_pkg::ETH_TYPE_IP, 2);
        push_bytes(16'h0604, 2);               // Address lengths
        push_bytes(op, 2);
        push_bytes(eth_pkg::LOCAL_MAC, 6);
        push_bytes(eth_pkg::LOCAL_IP, 4);
        push_bytes(tha, 6);
        push_bytes(tip, 4);
        pad_frame();
    endtask

    // Peer ARP frame on the receive side, padded to 60 bytes
    task automatic inject_arp(input logic [15:0] op, input logic [47:0] sha,
                              input logic [31:0] spa, input logic [31:0] tpa);
        logic [335:0] f;
        logic [47:0]  dst;
        dst = (op == eth_pkg::ARP_REQUEST) ? 48'hFFFF_FFFF_FFFF : eth_pkg::LOCAL_MAC;
        f   = {dst, sha, eth_pkg::ETH_TYPE_ARP, 16'h0001, eth_pkg::ETH_TYPE_IP, 16'h0604,
               op, sha, spa, 48'd0, tpa};
        for (int i = 0; i < 60; i++) begin
            gmii_rxdv = 1'b1;
            gmii_rxd  = (i < 42) ? f[335 - 8*i -: 8] : 8'h00;
            @(posedge clk);
            #1;
        end
        gmii_rxdv = 1'b0;
        gmii_rxd  = 8'h00;
    endtask

    // Records one frame, checks txen is gapless and tlast marks the final byte
    task automatic collect_frame(input string name, input int start_limit);
        int n;
        got.delete();
        n = 0;
        while (!gmii_txen && n < start_limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!gmii_txen) begin
            errors++;
            $display("%s: no frame started within %0d cycles", name, start_limit);
            return;
        end
        n = 0;
        while (gmii_txen && !gmii_tlast && n < 200) begin
            got.push_back(gmii_txd);
            @(posedge clk);
            #1;
            n++;
        end
        if (gmii_tlast) begin
            got.push_back(gmii_txd);
        end else begin
            errors++;
            $display("%s: gmii_txen dropped or ran on without gmii_tlast", name);
        end
        @(posedge clk);
        #1;
        if (gmii_txen) begin
            errors++;
            $display("%s: gmii_txen still high after gmii_tlast", name);
        end
    endtask

    task automatic compare_frame(input string name);
        checks++;
        if (got.size() != exp_q.size()) begin
            errors++;
            $display("Fail %s length: expected %0d, actual %0d", name, exp_q.size(), got.size());
        end else begin
            for (int i = 0; i < got.size(); i++) begin
                if (got[i] !== exp_q[i]) begin
                    errors++;
                    $display("Fail %s byte %0d: expected %h, actual %h", name, i, exp_q[i],
                             got[i]);
                end
            end
        end
    endtask

    task automatic expect_silence(input string name, input int cycles);
        for (int n = 0; n < cycles; n++) begin
            if (gmii_txen) begin
                errors++;
                $display("%s: unexpected frame on GMII", name);
                return;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_idle(input string name);
        logic [31:0] d;
        int          n;
        n = 0;
        d = 32'd1;
        while (d[0] && n < 20) begin
            wb_read(eth_pkg::REG_CTRL, d);
            n++;
        end
        if (d[0]) begin
            errors++;
            $display("%s: busy did not clear", name);
        end
    endtask

    task automatic udp_round(input string name, input logic set_mac, input logic [47:0] mac);
        logic [31:0] ip;
        int          len;
        ip  = $random(seed);
        len = ($random(seed) & 32'h3F) + 1;
        for (int i = 0; i < 64; i++) pay[i] = $random(seed);
        if (set_mac) begin
            wb_write(eth_pkg::REG_DMAC_LO, mac[31:0]);
            wb_write(eth_pkg::REG_DMAC_HI, {16'd0, mac[47:32]});
        end
        wb_write(eth_pkg::REG_DIP, ip);
        wb_write(eth_pkg::REG_LEN, len);
        for (int w = 0; w < 16; w++)
            wb_write(eth_pkg::REG_PAYLOAD_BASE + 6'(w),
                     {pay[4*w], pay[4*w+1], pay[4*w+2], pay[4*w+3]});
        build_udp(mac, ip, len);
        fork
            wb_write(eth_pkg::REG_CTRL, 32'd1);
            collect_frame(name, 12); // Upper bound on start latency
        join
        compare_frame(name);
        wait_idle(name);
    endtask

    initial begin
        logic [47:0] mac;
        logic [31:0] ip;
        logic [31:0] d;
        logic [31:0] wd;
        logic [5:0]  adr;
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        gmii_rxdv = 1'b0;
        gmii_rxd  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        for (int k = 0; k < 12; k++) begin // Register readback
            case ($unsigned($random(seed)) % 3)
                0:       adr = eth_pkg::REG_DIP;
                1:       adr = eth_pkg::REG_LEN;
                default: adr = eth_pkg::REG_PAYLOAD_BASE + 6'($unsigned($random(seed)) % 16);
            endcase
            wd = $random(seed);
            if (adr == eth_pkg::REG_LEN) wd = (wd & 32'h3F) + 1;
            wb_write(adr, wd);
            wb_read(adr, d);
            checks++;
            if (d !== wd) begin
                errors++;
                $display("Fail reg_access %h: expected %h, actual %h", adr, wd, d);
            end
        end

        for (int r = 0; r < 20; r++) begin
            mac = {$random(seed), $random(seed)};
            if (mac == 48'd0) mac = 48'd1;
            udp_round($sformatf("udp_frame_%0d", r), 1'b1, mac);
        end

        ip = $random(seed); // Unknown MAC gives a broadcast request
        wb_write(eth_pkg::REG_DMAC_LO, 32'd0);
        wb_write(eth_pkg::REG_DMAC_HI, 32'd0);
        wb_write(eth_pkg::REG_DIP, ip);
        build_arp(eth_pkg::ARP_REQUEST, 48'hFFFF_FFFF_FFFF, 48'd0, ip);
        fork
            wb_write(eth_pkg::REG_CTRL, 32'd1);
            collect_frame("arp_request", 12);
        join
        compare_frame("arp_request");
        wait_idle("arp_request");

        mac = {$random(seed), $random(seed)};
        ip  = $random(seed);
        build_arp(eth_pkg::ARP_REPLY, mac, mac, ip);
        fork
            inject_arp(eth_pkg::ARP_REQUEST, mac, ip, eth_pkg::LOCAL_IP);
            collect_frame("arp_reply", 120);
        join
        compare_frame("arp_reply");
        wait_idle("arp_reply");
        fork // Request for another host
            inject_arp(eth_pkg::ARP_REQUEST, mac, ip, eth_pkg::LOCAL_IP ^ 32'h1);
            expect_silence("arp_other_ip", 150);
        join

        mac = {$random(seed), $random(seed)};
        if (mac == 48'd0) mac = 48'd1;
        inject_arp(eth_pkg::ARP_REPLY, mac, $random(seed), eth_pkg::LOCAL_IP);
        wb_read(eth_pkg::REG_DMAC_LO, d);
        checks++;
        if (d !== mac[31:0]) begin
            errors++;
            $display("Fail mac_learn_lo: expected %h, actual %h", mac[31:0], d);
        end
        wb_read(eth_pkg::REG_DMAC_HI, d);
        checks++;
        if (d !== {16'd0, mac[47:32]}) begin
            errors++;
            $display("Fail mac_learn_hi: expected %h, actual %h", {16'd0, mac[47:32]}, d);
        end
        udp_round("udp_learned_mac", 1'b0, mac);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- flist.f
source/eth_pkg.sv
source/eth_host_regs.sv
source/arp_rx.sv
source/arp_tx.sv
source/udp_tx.sv
source/eth_ctrl.sv
source/eth_subsys_top.sv
sim/eth_subsys_tb.sv

//--- Bender.yml
package:
  name: eth_subsys

sources:
  - source/eth_pkg.sv
  - source/eth_host_regs.sv
  - source/arp_rx.sv
  - source/arp_tx.sv
  - source/udp_tx.sv
  - source/eth_ctrl.sv
  - source/eth_subsys_top.sv
  - target: test
    files:
      - sim/eth_subsys_tb.sv
